// File: common/camera_pkg.sv
package camera_pkg;

  // camera bus and pixel words

  // one byte off the parallel camera bus
  typedef logic [7:0] byte_t;

  // 5:6:5 pixel
  // red in [15:11], green in [10:5], blue in [4:0]
  typedef logic [15:0] pixel_t;

  // position counters

  // column inside a line, wide enough for 1280
  typedef logic [10:0] hcount_t;

  // line inside a frame, wide enough for 720
  typedef logic [9:0] vcount_t;

  // colour and threshold values

  // red chroma, offset by 128 so it reads as unsigned
  typedef logic [7:0] chroma_t;

  // threshold switch setting
  // bound is the nibble in the upper half of a chroma value
  typedef logic [3:0] nibble_t;

  // constants

  // keep every fourth pixel of every fourth line
  localparam int DS_SHIFT = 2;

  // cycles from pixel_valid to mask_valid in chroma_mask
  localparam int CHROMA_LATENCY = 3;

endpackage

// File: capture/pixel_assembler.sv
`timescale 1ns/1ps

module pixel_assembler #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  camera_pkg::byte_t   cam_data_i,
  input  logic                cam_pclk_i,
  input  logic                cam_hsync_i,
  input  logic                cam_vsync_i,
  output logic                pixel_valid_o,
  output camera_pkg::pixel_t  pixel_o,
  output camera_pkg::hcount_t hcount_o,
  output camera_pkg::vcount_t vcount_o
);
  import camera_pkg::*;

  // two-flop synchronizers for the whole camera bus
  byte_t   data_meta;
  byte_t   data_sync;
  logic    pclk_meta;
  logic    pclk_sync;
  logic    hsync_meta;
  logic    hsync_sync;
  logic    vsync_meta;
  logic    vsync_sync;

  // previous synced levels, for edge detection
  logic    pclk_prev;
  logic    hsync_prev;

  logic    pclk_rise;
  logic    hsync_fall;
  logic    take_byte;

  // 0 while waiting for the high byte
  logic    byte_phase;
  byte_t   high_byte;

  // running position of the pixel being built
  hcount_t h_pos;
  vcount_t v_pos;

  always_ff @(posedge clk_camera) begin
    data_meta  <= cam_data_i;
    data_sync  <= data_meta;
    pclk_meta  <= cam_pclk_i;
    pclk_sync  <= pclk_meta;
    hsync_meta <= cam_hsync_i;
    hsync_sync <= hsync_meta;
    vsync_meta <= cam_vsync_i;
    vsync_sync <= vsync_meta;
    pclk_prev  <= pclk_sync;
    hsync_prev <= hsync_sync;
  end

  assign pclk_rise  = pclk_sync && !pclk_prev;
  assign hsync_fall = hsync_prev && !hsync_sync;
  // bytes only count inside active video
  assign take_byte  = pclk_rise && hsync_sync && vsync_sync;

  // byte phase, column counter and the valid strobe
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      byte_phase    <= 1'b0;
      h_pos         <= '0;
      pixel_valid_o <= 1'b0;
    end else begin
      // pulse one cycle after the edge that brings the low byte
      pixel_valid_o <= take_byte && byte_phase;
      if (!hsync_sync) begin
        byte_phase <= 1'b0;
        h_pos      <= '0;
      end else if (take_byte) begin
        byte_phase <= !byte_phase;
        // step only once the pair is complete
        if (byte_phase) begin
          h_pos <= h_pos + 1'b1;
        end
      end
    end
  end

  // line counter, steps at the end of each line
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      v_pos <= '0;
    end else if (!vsync_sync) begin
      v_pos <= '0;
    end else if (hsync_fall) begin
      v_pos <= v_pos + 1'b1;
    end
  end

  // payload, held until the next completed pixel
  always_ff @(posedge clk_camera) begin
    if (take_byte && !byte_phase) begin
      high_byte <= data_sync;
    end
    if (take_byte && byte_phase) begin
      pixel_o  <= {high_byte, data_sync};
      hcount_o <= h_pos;
      vcount_o <= v_pos;
    end
  end

  // camera framing must keep every pixel inside the active area
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    pixel_valid_o |-> (hcount_o < H_ACTIVE) && (vcount_o < V_ACTIVE));

endmodule

// File: logic/chroma_mask.sv
`timescale 1ns/1ps

module chroma_mask (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  logic                 pixel_valid_i,
  input  camera_pkg::pixel_t   pixel_i,
  input  camera_pkg::hcount_t  hcount_i,
  input  camera_pkg::vcount_t  vcount_i,
  input  camera_pkg::nibble_t  lower_thresh_i,
  input  camera_pkg::nibble_t  upper_thresh_i,
  output logic                 mask_valid_o,
  output logic                 mask_o,
  output camera_pkg::hcount_t  hcount_o,
  output camera_pkg::vcount_t  vcount_o
);
  import camera_pkg::*;

  // 5:6:5 fields padded out to 8 bits
  logic [7:0]         red8;
  logic [7:0]         green8;
  logic [7:0]         blue8;

  // stage 1 products
  logic signed [17:0] red_term;
  logic signed [17:0] green_term;
  logic signed [17:0] blue_term;

  // stage 2 sum
  logic signed [17:0] cr_sum;

  // stage 3 inputs
  logic signed [17:0] cr_full;
  chroma_t            cr_value;
  chroma_t            lower_bound;
  chroma_t            upper_bound;

  // valid and position ride alongside the data
  logic [CHROMA_LATENCY-1:0] valid_dly;
  hcount_t                   h_dly [CHROMA_LATENCY];
  vcount_t                   v_dly [CHROMA_LATENCY];

  assign red8   = {pixel_i[15:11], 3'b000};
  assign green8 = {pixel_i[10:5], 2'b00};
  assign blue8  = {pixel_i[4:0], 3'b000};

  // Cr = 0.439 R - 0.368 G - 0.071 B, scaled by 256
  always_ff @(posedge clk_camera) begin
    red_term   <= $signed({10'b0, red8}) * 18'sd112;
    green_term <= -($signed({10'b0, green8}) * 18'sd94);
    blue_term  <= -($signed({10'b0, blue8}) * 18'sd18);
  end

  always_ff @(posedge clk_camera) begin
    cr_sum <= red_term + green_term + blue_term;
  end

  // arithmetic shift floors, then offset into unsigned range
  assign cr_full  = (cr_sum >>> 8) + 18'sd128;
  assign cr_value = cr_full[7:0];

  // switch nibble sits in the top half of the bound
  assign lower_bound = {lower_thresh_i, 4'b0000};
  assign upper_bound = {upper_thresh_i, 4'b0000};

  // window is open below, closed above
  always_ff @(posedge clk_camera) begin
    mask_o <= (cr_value > lower_bound) && (cr_value <= upper_bound);
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_dly <= '0;
    end else begin
      valid_dly <= {valid_dly[CHROMA_LATENCY-2:0], pixel_valid_i};
    end
  end

  always_ff @(posedge clk_camera) begin
    h_dly[0] <= hcount_i;
    v_dly[0] <= vcount_i;
    for (int i = 1; i < CHROMA_LATENCY; i++) begin
      h_dly[i] <= h_dly[i-1];
      v_dly[i] <= v_dly[i-1];
    end
  end

  assign mask_valid_o = valid_dly[CHROMA_LATENCY-1];
  assign hcount_o     = h_dly[CHROMA_LATENCY-1];
  assign vcount_o     = v_dly[CHROMA_LATENCY-1];

  // strobe leaves exactly as many cycles later as the data pipe is deep
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    mask_valid_o == $past(pixel_valid_i, CHROMA_LATENCY));

endmodule

// File: logic/mask_buffer.sv
`timescale 1ns/1ps

module mask_buffer #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic                mask_valid_i,
  input  logic                mask_i,
  input  camera_pkg::hcount_t hcount_i,
  input  camera_pkg::vcount_t vcount_i,
  input  camera_pkg::hcount_t disp_hcount_i,
  input  camera_pkg::vcount_t disp_vcount_i,
  output logic                mask_o
);
  import camera_pkg::*;

  // downsampled frame geometry
  localparam int COLS   = H_ACTIVE >> DS_SHIFT;
  localparam int ROWS   = V_ACTIVE >> DS_SHIFT;
  localparam int DEPTH  = COLS * ROWS;
  localparam int ADDR_W = $clog2(DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  // one bit per kept cell
  logic  mem [DEPTH];

  // write side
  logic  keep_sample;
  logic  wr_en;
  addr_t wr_addr;
  logic  wr_data;

  // read side
  logic  disp_in_frame;
  addr_t rd_addr;
  logic  rd_in_frame;
  logic  out_in_frame;
  logic  mem_q;

  // mirrored cell address, column counted from the right edge
  function automatic addr_t cell_addr(input hcount_t h, input vcount_t v);
    int col;
    int row;
    col = COLS - 1 - int'(h >> DS_SHIFT);
    row = int'(v >> DS_SHIFT);
    return addr_t'(col + COLS * row);
  endfunction

  // every fourth pixel of every fourth line
  assign keep_sample = mask_valid_i
                    && (hcount_i[DS_SHIFT-1:0] == '0)
                    && (vcount_i[DS_SHIFT-1:0] == '0);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= keep_sample;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (keep_sample) begin
      wr_addr <= cell_addr(hcount_i, vcount_i);
      wr_data <= mask_i;
    end
  end

  assign disp_in_frame = (disp_hcount_i < H_ACTIVE) && (disp_vcount_i < V_ACTIVE);

  // park the address at 0 outside the frame
  always_ff @(posedge clk_camera) begin
    rd_addr <= disp_in_frame ? cell_addr(disp_hcount_i, disp_vcount_i) : '0;
  end

  // in-frame flag follows the read through both register stages
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      rd_in_frame  <= 1'b0;
      out_in_frame <= 1'b0;
    end else begin
      rd_in_frame  <= disp_in_frame;
      out_in_frame <= rd_in_frame;
    end
  end

  // read-first, old contents come out on a same-address write
  always_ff @(posedge clk_camera) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    mem_q <= mem[rd_addr];
  end

  assign mask_o = out_in_frame && mem_q;

  // upstream counts must land every write inside the buffer
  assert property (@(posedge clk_camera) disable iff (recent_reset)
    wr_en |-> (wr_addr < DEPTH));

endmodule

// File: logic/camera_mask_top.sv
`timescale 1ns/1ps

module camera_mask_top #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  camera_pkg::byte_t   cam_data_i,
  input  logic                cam_pclk_i,
  input  logic                cam_hsync_i,
  input  logic                cam_vsync_i,
  input  camera_pkg::nibble_t lower_thresh_i,
  input  camera_pkg::nibble_t upper_thresh_i,
  input  camera_pkg::hcount_t disp_hcount_i,
  input  camera_pkg::vcount_t disp_vcount_i,
  output logic                mask_o
);
  import camera_pkg::*;

  // assembled pixel stream
  logic    pixel_valid;
  pixel_t  pixel;
  hcount_t pixel_hcount;
  vcount_t pixel_vcount;

  // thresholded stream
  logic    mask_valid;
  logic    mask_bit;
  hcount_t mask_hcount;
  vcount_t mask_vcount;

  pixel_assembler #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_pixel_assembler (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_data_i    (cam_data_i),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .pixel_valid_o (pixel_valid),
    .pixel_o       (pixel),
    .hcount_o      (pixel_hcount),
    .vcount_o      (pixel_vcount)
  );

  chroma_mask u_chroma_mask (
    .clk_camera     (clk_camera),
    .recent_reset   (recent_reset),
    .pixel_valid_i  (pixel_valid),
    .pixel_i        (pixel),
    .hcount_i       (pixel_hcount),
    .vcount_i       (pixel_vcount),
    .lower_thresh_i (lower_thresh_i),
    .upper_thresh_i (upper_thresh_i),
    .mask_valid_o   (mask_valid),
    .mask_o         (mask_bit),
    .hcount_o       (mask_hcount),
    .vcount_o       (mask_vcount)
  );

  // display read port, two cycles from coordinates to mask_o
  mask_buffer #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_mask_buffer (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .mask_valid_i  (mask_valid),
    .mask_i        (mask_bit),
    .hcount_i      (mask_hcount),
    .vcount_i      (mask_vcount),
    .disp_hcount_i (disp_hcount_i),
    .disp_vcount_i (disp_vcount_i),
    .mask_o        (mask_o)
  );

endmodule

// File: bench/camera_model.svh
`ifndef CAMERA_MODEL_SVH
`define CAMERA_MODEL_SVH

// expected mask per kept cell, camera orientation
// row is line / 4, column is pixel / 4
logic model_cells [FRAME_H / 4][FRAME_W / 4];

// red chroma, 8-bit fields scaled by 256
function automatic chroma_t model_cr(input pixel_t p);
  int r;
  int g;
  int b;
  int sum;
  // 5:6:5 fields padded with low zeros
  r   = int'(p[15:11]) * 8;
  g   = int'(p[10:5]) * 4;
  b   = int'(p[4:0]) * 8;
  sum = 112 * r - 94 * g - 18 * b;
  // floor of sum / 256, negative sums too
  return chroma_t'((sum >>> 8) + 128);
endfunction

// window open at the lower bound, closed at the upper
function automatic logic model_mask(input pixel_t p, input nibble_t lo, input nibble_t hi);
  int cr;
  cr = int'(model_cr(p));
  return (cr > 16 * int'(lo)) && (cr <= 16 * int'(hi));
endfunction

// only every fourth pixel of every fourth line is kept
task automatic record_pixel(input int h, input int v, input pixel_t p,
                            input nibble_t lo, input nibble_t hi);
  if ((h % 4 == 0) && (v % 4 == 0)) begin
    model_cells[v / 4][h / 4] = model_mask(p, lo, hi);
  end
endtask

// display read, zero off the frame
function automatic logic model_read(input int h, input int v);
  if ((h >= FRAME_W) || (v >= FRAME_H)) begin
    return 1'b0;
  end
  return model_cells[v / 4][h / 4];
endfunction

`endif

// File: bench/tb_camera_mask.sv
`timescale 1ns/1ps

module tb_camera_mask;
  import camera_pkg::*;

  localparam logic [31:0] SEED = 32'hb520_3607;
  localparam int FRAME_W = 32;
  localparam int FRAME_H = 16;
  // clk_camera cycles per pclk level
  localparam int PCLK_HALF = 4;
  localparam int HBLANK = 6;
  // pclk periods per frame with two bytes a pixel plus blanking
  localparam int FRAME_PCLKS = FRAME_H * (2 * FRAME_W + HBLANK) + 8;
  localparam int FRAME_CYCLES = FRAME_PCLKS * 2 * PCLK_HALF;
  // sweep runs past both frame edges
  localparam int SWEEP_W = FRAME_W + 8;
  localparam int SWEEP_H = FRAME_H + 4;
  localparam int SWEEP_CYCLES = SWEEP_W * SWEEP_H + 2;
  localparam int BURST_PCLKS = 40;
  // twice the length of four frames, one burst and five sweeps
  localparam int CYCLE_LIMIT = 2 * (4 * FRAME_CYCLES + BURST_PCLKS * 2 * PCLK_HALF
                                    + 5 * SWEEP_CYCLES + 100);

  logic    clk_camera;
  logic    recent_reset;
  byte_t   cam_data;
  logic    cam_pclk;
  logic    cam_hsync;
  logic    cam_vsync;
  nibble_t lower_thresh;
  nibble_t upper_thresh;
  hcount_t disp_hcount;
  vcount_t disp_vcount;
  logic    mask;
  int      cycle_count = 0;
  // reads in flight through the two-cycle port
  logic    expect_q [$];

  `include "camera_model.svh"

  camera_mask_top #(
    .H_ACTIVE (FRAME_W),
    .V_ACTIVE (FRAME_H)
  ) dut0 (
    .clk_camera     (clk_camera),
    .recent_reset   (recent_reset),
    .cam_data_i     (cam_data),
    .cam_pclk_i     (cam_pclk),
    .cam_hsync_i    (cam_hsync),
    .cam_vsync_i    (cam_vsync),
    .lower_thresh_i (lower_thresh),
    .upper_thresh_i (upper_thresh),
    .disp_hcount_i  (disp_hcount),
    .disp_vcount_i  (disp_vcount),
    .mask_o         (mask)
  );

  initial begin
    clk_camera = 1'b0;
    forever #5 clk_camera = ~clk_camera;
  end

  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, run still going after %0d cycles", cycle_count);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // n edges and then 1 ns past the last
  task automatic next_cycle(input int n);
    repeat (n) @(posedge clk_camera);
    #1;
  endtask

  task automatic check_mask(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s expected %0b actual %0b", test, expected, actual);
      $display("Test failed");
      $fatal(1, "mask mismatch");
    end
  endtask

  // one pclk period with the byte set up while pclk is low
  task automatic send_byte(input byte_t data, input logic hs, input logic vs);
    cam_data  = data;
    cam_hsync = hs;
    cam_vsync = vs;
    cam_pclk  = 1'b0;
    next_cycle(PCLK_HALF);
    cam_pclk  = 1'b1;
    next_cycle(PCLK_HALF);
  endtask

  task automatic send_frame(input nibble_t lo, input nibble_t hi);
    pixel_t p;
    lower_thresh = lo;
    upper_thresh = hi;
    // vsync goes up two bytes ahead of line 0
    repeat (4) send_byte(byte_t'($urandom), 1'b0, 1'b0);
    repeat (2) send_byte(byte_t'($urandom), 1'b0, 1'b1);
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        p = pixel_t'($urandom);
        record_pixel(h, v, p, lo, hi);
        // high byte first
        send_byte(p[15:8], 1'b1, 1'b1);
        send_byte(p[7:0], 1'b1, 1'b1);
      end
      // junk on the bus during hblank
      repeat (HBLANK) send_byte(byte_t'($urandom), 1'b0, 1'b1);
    end
    repeat (2) send_byte(byte_t'($urandom), 1'b0, 1'b0);
  endtask

  // pclk keeps running while the syncs are never both high
  task automatic blanking_burst();
    logic hs;
    logic vs;
    for (int i = 0; i < BURST_PCLKS; i++) begin
      hs = 1'($urandom);
      vs = hs ? 1'b0 : 1'($urandom);
      send_byte(byte_t'($urandom), hs, vs);
    end
    send_byte(byte_t'($urandom), 1'b0, 1'b0);
  endtask

  // raster over the frame plus an off-frame margin
  task automatic sweep(input string test, input logic all_zero);
    expect_q.delete();
    for (int v = 0; v < SWEEP_H; v++) begin
      for (int h = 0; h < SWEEP_W; h++) begin
        disp_hcount = hcount_t'(h);
        disp_vcount = vcount_t'(v);
        expect_q.push_back(all_zero ? 1'b0 : model_read(h, v));
        next_cycle(1);
        // result of the read two cycles back
        if (expect_q.size() == 2) begin
          check_mask(test, expect_q.pop_front(), mask);
        end
      end
    end
    while (expect_q.size() > 0) begin
      next_cycle(1);
      check_mask(test, expect_q.pop_front(), mask);
    end
  endtask

  initial begin
    nibble_t lo;
    nibble_t hi;
    void'($urandom(SEED));
    recent_reset = 1'b1;
    cam_data     = '0;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    lower_thresh = '0;
    upper_thresh = '0;
    disp_hcount  = '0;
    disp_vcount  = '0;
    // mask_o low through reset and one cycle past it
    for (int i = 0; i < 4; i++) begin
      next_cycle(1);
      check_mask("reset", 1'b0, mask);
    end
    recent_reset = 1'b0;
    next_cycle(1);
    check_mask("reset_release", 1'b0, mask);
    lo = nibble_t'($urandom_range(7, 0));
    hi = nibble_t'($urandom_range(15, 8));
    send_frame(lo, hi);
    sweep("random_frame", 1'b0);
    // new pixels and bounds replace every cell
    lo = nibble_t'($urandom_range(7, 0));
    hi = nibble_t'($urandom_range(15, 8));
    send_frame(lo, hi);
    sweep("second_frame", 1'b0);
    lo = nibble_t'($urandom);
    send_frame(lo, lo);
    sweep("empty_window", 1'b1);
    // buffer holds all zeros and the full window turns any stray pixel into a 1
    lower_thresh = 4'd0;
    upper_thresh = 4'd15;
    blanking_burst();
    sweep("blanking", 1'b0);
    send_frame(4'd0, 4'd15);
    sweep("wide_window", 1'b0);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: list.f
+incdir+bench
common/camera_pkg.sv
capture/pixel_assembler.sv
logic/chroma_mask.sv
logic/mask_buffer.sv
logic/camera_mask_top.sv
bench/tb_camera_mask.sv

// File: run.sh
#!/bin/sh
# build and run the camera mask testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_camera_mask \
  -f list.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_camera_mask > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
